/* hw/icache_pkg.sv */
`default_nettype none

package icache_pkg;

	// default fetch and bus address width
	localparam int ADDR_W = 32;

	// cache geometry
	localparam int WAYS       = 4;
	localparam int SETS       = 64;
	localparam int LINE_BYTES = 16;
	localparam int INDEX_W    = 6;                         // log2(SETS)
	localparam int OFF_W      = 4;                         // log2(LINE_BYTES)
	localparam int TAG_W      = ADDR_W - INDEX_W - OFF_W;  // tag bits at the default width
	localparam int LINE_W     = LINE_BYTES * 8;            // 128 bit line

	// controller states
	typedef enum logic [1:0] {
		ST_IDLE   = 2'd0,  // nothing to return
		ST_LOOKUP = 2'd1,  // hit data coming from a way SRAM
		ST_REFILL = 2'd2,  // waiting on the line from memory
		ST_RESP   = 2'd3   // answering from the refilled line
	} ctrl_state_e;

	// AXI response codes
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_EXOKAY = 2'b01,
		RESP_SLVERR = 2'b10,
		RESP_DECERR = 2'b11
	} axi_resp_e;

endpackage

`default_nettype wire

/* hw/icache_data_sram.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_data_sram (
	input  logic                          clk,
	input  logic                          en,
	input  logic                          we,
	input  logic [icache_pkg::INDEX_W-1:0] index,
	input  logic [icache_pkg::LINE_W-1:0]  wdata,
	output logic [icache_pkg::LINE_W-1:0]  rdata
);
	import icache_pkg::*;

	logic [LINE_W-1:0] mem [SETS];  // one line per set

	// one port, either write or read per enabled cycle
	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				mem[index] <= wdata;
			end else begin
				rdata <= mem[index];  // registered read data
			end
		end
	end

	// the controller must never enable a way with a floating set index
	a_index_known: assert property (
		@(posedge clk) en |-> !$isunknown(index)
	) else $error("sram enabled with unknown index");

endmodule

`default_nettype wire

/* hw/icache_tag_array.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_tag_array #(
	parameter int ADDR_W = icache_pkg::ADDR_W
) (
	input  logic                       clk,
	input  logic                       rst,
	input  logic [ADDR_W-1:0]          lookup_addr,
	output logic [icache_pkg::WAYS-1:0] way_hit,
	input  logic                       fill_en,
	input  logic [icache_pkg::WAYS-1:0] fill_way,
	input  logic [ADDR_W-1:0]          fill_addr
);
	import icache_pkg::*;

	localparam int TAG_BITS = ADDR_W - INDEX_W - OFF_W;

	logic [TAG_BITS-1:0] tag_q [WAYS][SETS];
	logic [SETS-1:0]     valid_q [WAYS];

	logic [INDEX_W-1:0]  lk_index;
	logic [TAG_BITS-1:0] lk_tag;
	logic [INDEX_W-1:0]  fl_index;
	logic [TAG_BITS-1:0] fl_tag;

	assign lk_index = lookup_addr[INDEX_W+OFF_W-1:OFF_W];
	assign lk_tag   = lookup_addr[ADDR_W-1:INDEX_W+OFF_W];
	assign fl_index = fill_addr[INDEX_W+OFF_W-1:OFF_W];
	assign fl_tag   = fill_addr[ADDR_W-1:INDEX_W+OFF_W];

	// compare all ways of the addressed set at once
	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			way_hit[w] = valid_q[w][lk_index] && (tag_q[w][lk_index] == lk_tag);
		end
	end

	// valid bits, cleared on reset
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < WAYS; w++) begin
				valid_q[w] <= '0;
			end
		end else if (fill_en) begin
			for (int w = 0; w < WAYS; w++) begin
				if (fill_way[w]) begin
					valid_q[w][fl_index] <= 1'b1;
				end
			end
		end
	end

	// tag storage
	always_ff @(posedge clk) begin
		if (fill_en) begin
			for (int w = 0; w < WAYS; w++) begin
				if (fill_way[w]) begin
					tag_q[w][fl_index] <= fl_tag;
				end
			end
		end
	end

	// a line lives in one way only, so a second copy means the victim logic broke
	a_hit_onehot: assert property (
		@(posedge clk) disable iff (rst) $onehot0(way_hit)
	) else $error("line present in more than one way");

	a_fill_onehot: assert property (
		@(posedge clk) disable iff (rst) fill_en |-> $onehot(fill_way)
	) else $error("fill_way not one-hot");

endmodule

`default_nettype wire

/* hw/icache_refill_axil.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_refill_axil #(
	parameter int ADDR_W = icache_pkg::ADDR_W
) (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         refill_start,
	input  logic [ADDR_W-1:0]            refill_addr,
	output logic                         refill_done,
	output logic [icache_pkg::LINE_W-1:0] refill_line,
	output logic                         refill_err,
	output logic [ADDR_W-1:0]            araddr,
	output logic                         arvalid,
	input  logic                         arready,
	input  logic [31:0]                  rdata,
	input  logic [1:0]                   rresp,
	input  logic                         rvalid,
	output logic                         rready
);
	import icache_pkg::*;

	localparam int WORDS = LINE_BYTES / 4;
	localparam int CNT_W = OFF_W - 2;

	logic                     busy_q;
	logic [CNT_W-1:0]         cnt_q;     // word being fetched
	logic [ADDR_W-OFF_W-1:0]  base_q;    // line address
	logic [LINE_W-1:0]        line_q;
	logic                     err_q;
	logic                     beat;
	logic                     bad_resp;

	assign beat     = rvalid && rready;
	assign bad_resp = axi_resp_e'(rresp) != RESP_OKAY;

	assign araddr      = {base_q, cnt_q, 2'b00};
	assign refill_line = line_q;
	assign refill_err  = err_q;

	// control side, one read in flight at a time
	always_ff @(posedge clk) begin
		if (rst) begin
			busy_q      <= 1'b0;
			arvalid     <= 1'b0;
			rready      <= 1'b0;
			refill_done <= 1'b0;
			cnt_q       <= '0;
			err_q       <= 1'b0;
		end else begin
			refill_done <= 1'b0;
			if (refill_start && !busy_q) begin
				busy_q  <= 1'b1;
				arvalid <= 1'b1;
				cnt_q   <= '0;
				err_q   <= 1'b0;
			end
			if (arvalid && arready) begin
				arvalid <= 1'b0;
				rready  <= 1'b1;
			end
			if (beat) begin
				rready <= 1'b0;
				err_q  <= err_q | bad_resp;  // sticky for the whole line
				if (cnt_q == CNT_W'(WORDS - 1)) begin
					busy_q      <= 1'b0;
					refill_done <= 1'b1;
				end else begin
					cnt_q   <= cnt_q + 1'b1;
					arvalid <= 1'b1;  // next word
				end
			end
		end
	end

	// payload side
	always_ff @(posedge clk) begin
		if (refill_start && !busy_q) begin
			base_q <= refill_addr[ADDR_W-1:OFF_W];
		end
		if (beat) begin
			line_q[cnt_q*32 +: 32] <= rdata;  // lane per word
		end
	end

	a_ar_hold: assert property (
		@(posedge clk) disable iff (rst)
		arvalid && !arready |=> arvalid && $stable(araddr)
	) else $error("AR request dropped or changed before arready");

	// controller must wait for refill_done before the next start
	a_no_overlap: assert property (
		@(posedge clk) disable iff (rst) refill_start |-> !busy_q
	) else $error("refill_start while a refill is running");

endmodule

`default_nettype wire

/* hw/icache_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_ctrl #(
	parameter int ADDR_W = icache_pkg::ADDR_W
) (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          req_valid,
	input  logic [ADDR_W-1:0]             req_addr,
	output logic                          req_ready,
	output logic                          resp_valid,
	input  logic                          resp_ready,
	output logic [31:0]                   resp_inst,
	output logic                          resp_err,
	input  logic                          flush,
	output logic [ADDR_W-1:0]             lookup_addr,
	input  logic [icache_pkg::WAYS-1:0]    way_hit,
	output logic                          fill_en,
	output logic [icache_pkg::WAYS-1:0]    fill_way,
	output logic [ADDR_W-1:0]             fill_addr,
	output logic [icache_pkg::WAYS-1:0]    sram_en,
	output logic                          sram_we,
	output logic [icache_pkg::INDEX_W-1:0] sram_index,
	output logic [icache_pkg::LINE_W-1:0]  sram_wdata,
	input  logic [icache_pkg::LINE_W-1:0]  sram_rdata0,
	input  logic [icache_pkg::LINE_W-1:0]  sram_rdata1,
	input  logic [icache_pkg::LINE_W-1:0]  sram_rdata2,
	input  logic [icache_pkg::LINE_W-1:0]  sram_rdata3,
	output logic                          refill_start,
	output logic [ADDR_W-1:0]             refill_addr,
	input  logic                          refill_done,
	input  logic [icache_pkg::LINE_W-1:0]  refill_line,
	input  logic                          refill_err
);
	import icache_pkg::*;

	ctrl_state_e       state_q;
	logic [ADDR_W-1:0] addr_q;      // address of the fetch being answered
	logic [WAYS-1:0]   hit_q;
	logic [WAYS-1:0]   victim_q;    // rotating one-hot
	logic [WAYS-1:0]   fill_way_q;
	logic              resp_err_q;
	logic              drop_q;      // refill flushed, no answer
	logic              held_q;
	logic [31:0]       inst_hold_q;
	logic [31:0]       sel_inst;
	logic [LINE_W-1:0] way_data [WAYS];
	logic [LINE_W-1:0] hit_line;
	logic [LINE_W-1:0] resp_line;
	logic              accept;
	logic              hit;
	logic              refill_end;

	assign hit        = |way_hit;
	assign resp_valid = (state_q == ST_LOOKUP) || (state_q == ST_RESP);
	assign req_ready  = !flush && ((state_q == ST_IDLE) || (resp_valid && resp_ready));
	assign accept     = req_valid && req_ready;
	assign refill_end = (state_q == ST_REFILL) && refill_done;

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q      <= ST_IDLE;
			victim_q     <= WAYS'(1);
			refill_start <= 1'b0;
			drop_q       <= 1'b0;
			held_q       <= 1'b0;
		end else begin
			refill_start <= accept && !hit;  // one cycle pulse after the miss
			held_q       <= resp_valid && !resp_ready && !flush;
			if (accept) begin
				victim_q <= {victim_q[WAYS-2:0], victim_q[WAYS-1]};
				drop_q   <= 1'b0;
			end else if ((state_q == ST_REFILL) && flush) begin
				drop_q <= 1'b1;
			end
			case (state_q)
				ST_REFILL: begin
					if (refill_done) begin
						state_q <= (drop_q || flush) ? ST_IDLE : ST_RESP;
					end
				end
				default: begin
					if (flush) begin
						state_q <= ST_IDLE;
					end else if (accept) begin
						state_q <= hit ? ST_LOOKUP : ST_REFILL;
					end else if (resp_valid && resp_ready) begin
						state_q <= ST_IDLE;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			addr_q     <= req_addr;
			hit_q      <= way_hit;
			fill_way_q <= victim_q;  // victim picked at accept time
			resp_err_q <= 1'b0;
		end else if (refill_end) begin
			resp_err_q <= refill_err;
		end
		if (!held_q) begin
			inst_hold_q <= sel_inst;  // frozen on the first stalled cycle
		end
	end

	assign way_data[0] = sram_rdata0;
	assign way_data[1] = sram_rdata1;
	assign way_data[2] = sram_rdata2;
	assign way_data[3] = sram_rdata3;

	always_comb begin
		hit_line = '0;
		for (int w = 0; w < WAYS; w++) begin
			if (hit_q[w]) begin
				hit_line = hit_line | way_data[w];
			end
		end
	end

	assign resp_line = (state_q == ST_LOOKUP) ? hit_line : refill_line;
	assign sel_inst  = resp_line[addr_q[OFF_W-1:2]*32 +: 32];
	assign resp_inst = held_q ? inst_hold_q : sel_inst;
	assign resp_err  = resp_err_q;

	assign lookup_addr = req_addr;
	assign refill_addr = addr_q;
	assign fill_en     = refill_end && !refill_err;  // a failed line stays out
	assign fill_way    = fill_way_q;
	assign fill_addr   = addr_q;

	// SRAM port shared by hit reads and refill writes
	always_comb begin
		sram_en = '0;
		if (fill_en) begin
			sram_en = fill_way_q;
		end else if (accept && hit) begin
			sram_en = way_hit;
		end
	end

	assign sram_we    = state_q == ST_REFILL;
	assign sram_index = (state_q == ST_REFILL) ? addr_q[INDEX_W+OFF_W-1:OFF_W]
	                                           : req_addr[INDEX_W+OFF_W-1:OFF_W];
	assign sram_wdata = refill_line;

	a_resp_stable: assert property (
		@(posedge clk) disable iff (rst)
		resp_valid && !resp_ready && !flush
		|=> resp_valid && $stable(resp_inst) && $stable(resp_err)
	) else $error("response changed while stalled");

endmodule

`default_nettype wire

/* hw/icache_top.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_top #(
	parameter int ADDR_W = icache_pkg::ADDR_W
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              req_valid,
	input  logic [ADDR_W-1:0] req_addr,
	output logic              req_ready,
	output logic              resp_valid,
	input  logic              resp_ready,
	output logic [31:0]       resp_inst,
	output logic              resp_err,
	input  logic              flush,
	output logic [ADDR_W-1:0] araddr,
	output logic              arvalid,
	input  logic              arready,
	input  logic [31:0]       rdata,
	input  logic [1:0]        rresp,
	input  logic              rvalid,
	output logic              rready
);
	import icache_pkg::*;

	logic [ADDR_W-1:0]  lookup_addr;
	logic [ADDR_W-1:0]  fill_addr;
	logic [ADDR_W-1:0]  refill_addr;
	logic [WAYS-1:0]    way_hit;
	logic [WAYS-1:0]    fill_way;
	logic [WAYS-1:0]    sram_en;
	logic               fill_en;
	logic               sram_we;
	logic               refill_start;
	logic               refill_done;
	logic               refill_err;
	logic [INDEX_W-1:0] sram_index;
	logic [LINE_W-1:0]  sram_wdata;
	logic [LINE_W-1:0]  refill_line;
	logic [LINE_W-1:0]  sram_rdata [WAYS];

	icache_tag_array #(.ADDR_W(ADDR_W)) u_tags (
		.clk(clk), .rst(rst), .lookup_addr(lookup_addr), .way_hit(way_hit),
		.fill_en(fill_en), .fill_way(fill_way), .fill_addr(fill_addr)
	);

	// one data SRAM per way
	for (genvar w = 0; w < WAYS; w++) begin : g_way
		icache_data_sram u_sram (
			.clk(clk), .en(sram_en[w]), .we(sram_we), .index(sram_index),
			.wdata(sram_wdata), .rdata(sram_rdata[w])
		);
	end

	icache_ctrl #(.ADDR_W(ADDR_W)) u_ctrl (
		.clk(clk), .rst(rst),
		.req_valid(req_valid), .req_addr(req_addr), .req_ready(req_ready),
		.resp_valid(resp_valid), .resp_ready(resp_ready),
		.resp_inst(resp_inst), .resp_err(resp_err), .flush(flush),
		.lookup_addr(lookup_addr), .way_hit(way_hit),
		.fill_en(fill_en), .fill_way(fill_way), .fill_addr(fill_addr),
		.sram_en(sram_en), .sram_we(sram_we), .sram_index(sram_index),
		.sram_wdata(sram_wdata),
		.sram_rdata0(sram_rdata[0]), .sram_rdata1(sram_rdata[1]),
		.sram_rdata2(sram_rdata[2]), .sram_rdata3(sram_rdata[3]),
		.refill_start(refill_start), .refill_addr(refill_addr),
		.refill_done(refill_done), .refill_line(refill_line), .refill_err(refill_err)
	);

	icache_refill_axil #(.ADDR_W(ADDR_W)) u_refill (
		.clk(clk), .rst(rst),
		.refill_start(refill_start), .refill_addr(refill_addr),
		.refill_done(refill_done), .refill_line(refill_line), .refill_err(refill_err),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
	);

endmodule

`default_nettype wire

/* tests/tb_clkgen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clkgen #(
	parameter int HALF_NS    = 4,
	parameter int RST_CYCLES = 4
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #(HALF_NS) clk = ~clk;
	end

	// released just after an edge, same as the other inputs
	initial begin
		rst = 1'b1;
		repeat (RST_CYCLES) @(posedge clk);
		#1;
		rst = 1'b0;
	end

endmodule

`default_nettype wire

/* tests/axil_mem_model.sv */
`timescale 1ns/10ps
`default_nettype none

module axil_mem_model (
	input  logic        clk,
	input  logic        rst,
	input  logic [31:0] araddr,
	input  logic        arvalid,
	output logic        arready,
	output logic [31:0] rdata,
	output logic [1:0]  rresp,
	output logic        rvalid,
	input  logic        rready
);
	import icache_pkg::*;

	int          seed;
	int          delay;     // cycles left before the R beat
	logic        busy;      // address taken, beat not sent yet
	logic [31:0] addr_q;
	logic [31:0] ar_addr_s;
	logic        ar_fire;
	logic        r_fire;

	initial begin
		seed    = 32'h4fcab53c;
		delay   = 0;
		busy    = 1'b0;
		addr_q  = '0;
		arready = 1'b0;
		rvalid  = 1'b0;
		rdata   = '0;
		rresp   = RESP_OKAY;
		forever begin
			@(posedge clk);
			ar_fire   = arvalid && arready;  // handshakes as seen at the edge
			ar_addr_s = araddr;
			r_fire    = rvalid && rready;
			#1;
			if (rst) begin
				arready = 1'b0;
				rvalid  = 1'b0;
				busy    = 1'b0;
			end else begin
				if (r_fire) begin
					rvalid = 1'b0;
					busy   = 1'b0;
				end
				if (ar_fire) begin
					addr_q = ar_addr_s;
					busy   = 1'b1;
					delay  = $random(seed) & 3;
				end
				if (busy && !rvalid) begin
					if (delay == 0) begin
						rvalid = 1'b1;
						rdata  = addr_q ^ 32'h5a5a0000;
						// upper half of the map answers with a slave error
						rresp  = addr_q[31] ? RESP_SLVERR : RESP_OKAY;
					end else begin
						delay = delay - 1;
					end
				end
				arready = !busy && (($random(seed) & 1) != 0);  // random AR stalls
			end
		end
	end

endmodule

`default_nettype wire

/* tests/tb_icache.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_icache;

	localparam int N_TESTS  = 6;
	localparam int CYCLE_NS = 8;

	logic        clk;
	logic        rst;
	logic        req_valid;
	logic [31:0] req_addr;
	logic        req_ready;
	logic        resp_valid;
	logic        resp_ready;
	logic [31:0] resp_inst;
	logic        resp_err;
	logic        flush;
	logic [31:0] araddr;
	logic        arvalid;
	logic        arready;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	logic        rvalid;
	logic        rready;

	logic [31:0] sb_q [$];   // accepted fetch addresses, oldest first
	logic [31:0] head;
	logic [31:0] exp_inst;
	logic        exp_err;
	logic [31:0] last_acc;
	logic [31:0] exp_araddr;
	logic [1:0]  ar_idx;     // word of the line being read
	int          sb_count;
	int          acc_count;
	int          rsp_count;
	int          ar_count;
	logic        hit_mode;
	logic        no_ar;
	int          errors = 0;
	int          passed = 0;
	int          failed = 0;
	int          test_errors;

	tb_clkgen #(.HALF_NS(CYCLE_NS / 2), .RST_CYCLES(4)) u_clk (.clk(clk), .rst(rst));

	icache_top #(.ADDR_W(32)) UUT (
		.clk(clk), .rst(rst),
		.req_valid(req_valid), .req_addr(req_addr), .req_ready(req_ready),
		.resp_valid(resp_valid), .resp_ready(resp_ready),
		.resp_inst(resp_inst), .resp_err(resp_err), .flush(flush),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
	);

	axil_mem_model u_mem (
		.clk(clk), .rst(rst), .araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
	);

	// memory contents as the bus model defines them
	function automatic logic [31:0] mem_word(input logic [31:0] addr);
		return {addr[31:2], 2'b00} ^ 32'h5a5a0000;
	endfunction

	task automatic log_error(input string msg);
		errors++;
		$display("%s at %0t ns", msg, $time);
	endtask

	always @(posedge clk) begin
		if (rst) begin
			sb_q.delete();
			ar_idx    <= 2'd0;
			acc_count <= 0;
			rsp_count <= 0;
			ar_count  <= 0;
		end else begin
			if (resp_valid && resp_ready) begin
				rsp_count <= rsp_count + 1;
			end
			if (flush) begin
				sb_q.delete();  // whatever was in flight gets no answer
			end else if (resp_valid && resp_ready && sb_q.size() != 0) begin
				void'(sb_q.pop_front());
			end
			if (req_valid && req_ready) begin
				sb_q.push_back(req_addr);
				last_acc  <= req_addr;
				acc_count <= acc_count + 1;
			end
			if (arvalid && arready) begin
				ar_idx   <= ar_idx + 2'd1;
				ar_count <= ar_count + 1;
			end
		end
		head = (sb_q.size() != 0) ? sb_q[0] : 32'h0;
		sb_count <= sb_q.size();
		exp_inst <= mem_word(head);
		exp_err  <= head[31];
	end

	assign exp_araddr = {last_acc[31:4], ar_idx, 2'b00};

	a_resp_owed: assert property (@(posedge clk) disable iff (rst)
		resp_valid |-> sb_count != 0
	) else log_error("response with no fetch outstanding");

	a_resp_inst: assert property (@(posedge clk) disable iff (rst)
		resp_valid && resp_ready |-> resp_inst == exp_inst
	) else log_error($sformatf("MISMATCH resp_inst got %08h expected %08h",
		$sampled(resp_inst), $sampled(exp_inst)));

	a_resp_err: assert property (@(posedge clk) disable iff (rst)
		resp_valid && resp_ready |-> resp_err == exp_err
	) else log_error($sformatf("MISMATCH resp_err got %0h expected %0h",
		$sampled(resp_err), $sampled(exp_err)));

	a_ar_addr: assert property (@(posedge clk) disable iff (rst)
		arvalid && arready |-> araddr == exp_araddr
	) else log_error($sformatf("MISMATCH araddr got %08h expected %08h",
		$sampled(araddr), $sampled(exp_araddr)));

	a_hit_latency: assert property (@(posedge clk) disable iff (rst)
		hit_mode && req_valid && req_ready |=> resp_valid
	) else log_error("hit response did not follow one cycle after accept");

	a_no_ar: assert property (@(posedge clk) disable iff (rst)
		no_ar |-> !arvalid
	) else log_error("AR request issued for a line that should hit");

	a_stall_hold: assert property (@(posedge clk) disable iff (rst)
		resp_valid && !resp_ready && !flush
		|=> resp_valid && $stable(resp_inst) && $stable(resp_err)
	) else log_error("response dropped or changed while stalled");

	a_stall_block: assert property (@(posedge clk) disable iff (rst)
		resp_valid && !resp_ready |-> !req_ready
	) else log_error("req_ready high while the response is stalled");

	// present one fetch and return once the cache took it
	task automatic fetch(input logic [31:0] addr);
		int start;
		start     = acc_count;
		req_valid = 1'b1;
		req_addr  = addr;
		while (acc_count == start) begin
			@(posedge clk);
			#1;
		end
		req_valid = 1'b0;
	endtask

	task automatic skip_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic drain();
		while (sb_count != 0) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic check_ar_count(input int from, input int expect_n);
		assert (ar_count - from == expect_n)
		else log_error($sformatf("MISMATCH ar_count got %0h expected %0h",
			ar_count - from, expect_n));
	endtask

	task automatic start_test();
		test_errors = errors;
	endtask

	task automatic report_test(input int num, input string name);
		if (errors == test_errors) begin
			passed++;
			$display("test %0d %s: ok", num, name);
		end else begin
			failed++;
			$display("test %0d %s: %0d error(s)", num, name, errors - test_errors);
		end
	endtask

	initial begin
		int a0;
		int r0;
		req_valid  = 1'b0;
		req_addr   = '0;
		resp_ready = 1'b1;
		flush      = 1'b0;
		hit_mode   = 1'b0;
		no_ar      = 1'b0;
		wait (!rst);
		@(posedge clk);
		#1;

		start_test();
		assert (req_ready && !resp_valid && !arvalid && !rready)
		else log_error("outputs not at their reset values");
		a0 = ar_count;
		fetch(32'h0000_1000);
		drain();
		check_ar_count(a0, 4);
		report_test(1, "cold miss");

		start_test();
		a0       = ar_count;
		hit_mode = 1'b1;
		no_ar    = 1'b1;
		fetch(32'h0000_1004);  // back to back, same line
		fetch(32'h0000_1008);
		fetch(32'h0000_100c);
		drain();
		hit_mode = 1'b0;
		no_ar    = 1'b0;
		check_ar_count(a0, 0);
		report_test(2, "hit after fill");

		start_test();
		a0 = ar_count;
		for (int k = 0; k < 5; k++) begin
			fetch(32'h0000_0050 + 32'h400 * k);  // all in set 5
		end
		drain();
		check_ar_count(a0, 20);
		a0 = ar_count;
		for (int k = 0; k < 5; k++) begin
			fetch(32'h0000_0050 + 32'h400 * k);
		end
		drain();
		assert (ar_count - a0 >= 4)
		else log_error("five lines of one set read back without any refill");
		report_test(3, "eviction");

		start_test();
		a0         = acc_count;
		resp_ready = 1'b0;
		fetch(32'h0000_3000);
		req_valid = 1'b1;
		req_addr  = 32'h0000_1004;  // queued behind the stalled answer
		while (!resp_valid) begin
			@(posedge clk);
			#1;
		end
		skip_cycles(10);
		assert (acc_count - a0 == 1)
		else log_error("second fetch accepted while the response was stalled");
		resp_ready = 1'b1;
		while (acc_count - a0 != 2) begin
			@(posedge clk);
			#1;
		end
		req_valid = 1'b0;
		drain();
		report_test(4, "back-pressure");

		start_test();
		r0 = rsp_count;
		fetch(32'h0000_4000);
		skip_cycles(2);  // refill still running
		flush = 1'b1;
		skip_cycles(1);
		flush = 1'b0;
		fetch(32'h0000_4008);
		drain();
		assert (rsp_count - r0 == 1)
		else log_error("flushed fetch still produced a response");
		report_test(5, "flush");

		start_test();
		a0 = ar_count;
		fetch(32'h8000_0100);
		drain();
		check_ar_count(a0, 4);
		a0 = ar_count;
		fetch(32'h8000_0104);  // failed line was never installed
		drain();
		check_ar_count(a0, 4);
		report_test(6, "bus error");

		$display("tests %0d, passed %0d, failed %0d, errors %0d",
			N_TESTS, passed, failed, errors);
		if (failed == 0 && errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	// each test may take up to 2000 cycles
	initial begin
		#(N_TESTS * 2000 * CYCLE_NS);
		$display("timeout after %0d cycles, the cache stopped answering", N_TESTS * 2000);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
hw/icache_pkg.sv
hw/icache_data_sram.sv
hw/icache_tag_array.sv
hw/icache_refill_axil.sv
hw/icache_ctrl.sv
hw/icache_top.sv
tests/tb_clkgen.sv
tests/axil_mem_model.sv
tests/tb_icache.sv

/* run.sh */
#!/bin/sh
# build the icache testbench with Verilator, run it, then look for the pass line in sim.log
rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module tb_icache -f files.f -o sim_icache \
	&& ./obj_dir/sim_icache | tee sim.log \
	|| echo "build or run failed"
grep -qx "=== PASS ===" sim.log 2>/dev/null \
	&& echo "result: pass" \
	|| { echo "result: fail"; exit 1; }
